// ==== common/storage_params.svh ====
`ifndef STORAGE_PARAMS_SVH
`define STORAGE_PARAMS_SVH

// Read/write RAM blocks behind strobe 0, from 1 up to 4
`define STORAGE_RAM_BLOCKS 2

// Window bases on bus address bits 23:0
`define STORAGE_RW_BASE_0 24'h00_0000

`define STORAGE_RW_BASE_1 24'h10_0000

`define STORAGE_RW_BASE_2 24'h30_0000

`define STORAGE_RW_BASE_3 24'h40_0000

// Strobe 1 window, second port of block 0
`define STORAGE_RO_BASE 24'h20_0000

// Applied before every window compare
`define STORAGE_ADR_MASK 24'hFF_0000

// Words per block
// 256 words gives the 8-bit macro address on bus bits 9:2
`define STORAGE_RAM_DEPTH 256

`endif

// ==== common/wb_pkg.sv ====
package wb_pkg;

    localparam int WB_ADR_W = 32;
    localparam int WB_DAT_W = 32;
    localparam int WB_SEL_W = WB_DAT_W / 8;
    localparam int WB_STB_W = 2;

    // Strobe bit positions
    localparam int WB_STB_RW = 0;
    localparam int WB_STB_RO = 1;

    // Byte address
    typedef logic [WB_ADR_W-1:0] wb_adr_t;

    typedef logic [WB_DAT_W-1:0] wb_dat_t;

    typedef logic [WB_SEL_W-1:0] wb_sel_t;

    // One bit per window, also used for the ack vector
    typedef logic [WB_STB_W-1:0] wb_stb_t;

endpackage

// ==== common/mem_pkg.sv ====
package mem_pkg;

    localparam int MEM_ADDR_W = 8;
    localparam int MEM_DATA_W = 32;
    localparam int MEM_BYTES  = MEM_DATA_W / 8;

    // Word address into one macro
    typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

    typedef logic [MEM_DATA_W-1:0] mem_word_t;

    // Low bit writes the matching byte
    typedef logic [MEM_BYTES-1:0] mem_mask_t;

endpackage

// ==== storage/sram_1rw1r.sv ====
`include "storage_params.svh"

module sram_1rw1r #(
    parameter int DEPTH = `STORAGE_RAM_DEPTH
) (
    input  logic               wb_clk_i,

    // Port 0, read/write
    input  logic               ena0_n_i,
    input  logic               wen0_n_i,
    input  mem_pkg::mem_mask_t wmask0_n_i,
    input  mem_pkg::mem_addr_t addr0_i,
    input  mem_pkg::mem_word_t wdata0_i,
    output mem_pkg::mem_word_t rdata0_o,

    // Port 1, read only
    input  logic               ena1_n_i,
    input  mem_pkg::mem_addr_t addr1_i,
    output mem_pkg::mem_word_t rdata1_o
);

    localparam int NBYTES = mem_pkg::MEM_BYTES;

    mem_pkg::mem_word_t mem [DEPTH];

    // Output registers come up at zero
    mem_pkg::mem_word_t rdata0_q = '0;
    mem_pkg::mem_word_t rdata1_q = '0;

    // Read returns the old word on a write to the same address
    always_ff @(posedge wb_clk_i) begin
        if (!ena0_n_i) begin
            if (!wen0_n_i) begin
                for (int i = 0; i < NBYTES; i++) begin
                    if (!wmask0_n_i[i]) begin
                        mem[addr0_i][i*8 +: 8] <= wdata0_i[i*8 +: 8];
                    end
                end
            end
            rdata0_q <= mem[addr0_i];
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (!ena1_n_i) begin
            rdata1_q <= mem[addr1_i];
        end
    end

    assign rdata0_o = rdata0_q;
    assign rdata1_o = rdata1_q;

    a_addr0_range: assert property (
        @(posedge wb_clk_i)
        !ena0_n_i |-> (int'(addr0_i) < DEPTH)
    ) else $error("port 0 address %0d beyond depth %0d", addr0_i, DEPTH);

    a_addr1_range: assert property (
        @(posedge wb_clk_i)
        !ena1_n_i |-> (int'(addr1_i) < DEPTH)
    ) else $error("port 1 address %0d beyond depth %0d", addr1_i, DEPTH);

endmodule

// ==== storage/storage_bridge_wb.sv ====
`include "storage_params.svh"

module storage_bridge_wb (
    input  logic                                        wb_clk_i,
    input  logic                                        rst_n_i,

    input  wb_pkg::wb_adr_t                             wb_adr_i,
    input  wb_pkg::wb_dat_t                             wb_dat_i,
    input  wb_pkg::wb_sel_t                             wb_sel_i,
    input  logic                                        wb_we_i,
    input  logic                                        wb_cyc_i,
    input  wb_pkg::wb_stb_t                             wb_stb_i,
    output wb_pkg::wb_stb_t                             wb_ack_o,
    output wb_pkg::wb_dat_t                             wb_rw_dat_o,
    output wb_pkg::wb_dat_t                             wb_ro_dat_o,

    output logic [`STORAGE_RAM_BLOCKS-1:0]              mem_ena_o,
    output logic [`STORAGE_RAM_BLOCKS-1:0]              mem_wen_o,
    output mem_pkg::mem_mask_t [`STORAGE_RAM_BLOCKS-1:0] mem_wmask_o,
    output mem_pkg::mem_addr_t                          mem_addr_o,
    output mem_pkg::mem_word_t                          mem_wdata_o,
    input  mem_pkg::mem_word_t [`STORAGE_RAM_BLOCKS-1:0] mem_rdata_i,

    output logic                                        ro_ena_o,
    output mem_pkg::mem_addr_t                          ro_addr_o,
    input  mem_pkg::mem_word_t                          ro_rdata_i
);

    localparam int NB = `STORAGE_RAM_BLOCKS;
    localparam int RW = wb_pkg::WB_STB_RW;
    localparam int RO = wb_pkg::WB_STB_RO;

    localparam logic [23:0] RW_BASE [4] = '{
        `STORAGE_RW_BASE_0,
        `STORAGE_RW_BASE_1,
        `STORAGE_RW_BASE_2,
        `STORAGE_RW_BASE_3
    };
    localparam logic [23:0] RO_BASE  = `STORAGE_RO_BASE;
    localparam logic [23:0] ADR_MASK = `STORAGE_ADR_MASK;

    wb_pkg::wb_stb_t valid;
    wb_pkg::wb_stb_t we_win;
    wb_pkg::wb_stb_t pend;
    wb_pkg::wb_stb_t ack_rd_q;
    wb_pkg::wb_stb_t done_q;
    logic [23:0]     win_adr;
    logic [NB-1:0]   rw_sel;
    logic            ro_sel;
    logic            rw_write;

    if (NB < 1 || NB > 4) begin : g_bad_cfg
        $error("storage_bridge_wb supports 1 to 4 RAM blocks, got %0d", NB);
    end

    assign valid = {2{wb_cyc_i}} & wb_stb_i;

    // The read-only window never writes, so its writes take the read path
    assign we_win[RW] = wb_we_i;
    assign we_win[RO] = 1'b0;

    // New access, not yet in flight and not yet answered
    assign pend = valid & ~ack_rd_q & ~wb_ack_o & ~done_q;

    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_ack_o <= '0;
            ack_rd_q <= '0;
            done_q   <= '0;
        end else begin
            wb_ack_o <= (pend & we_win) | ack_rd_q;
            ack_rd_q <= pend & ~we_win;
            // Held until the master drops the strobe
            done_q   <= valid & (done_q | wb_ack_o);
        end
    end

    // Address decoding
    assign win_adr  = wb_adr_i[23:0] & ADR_MASK;
    assign ro_sel   = (win_adr == RO_BASE);
    assign rw_write = valid[RW] & wb_we_i;

    for (genvar b = 0; b < NB; b++) begin : g_blk
        assign rw_sel[b]      = (win_adr == RW_BASE[b]);
        assign mem_ena_o[b]   = ~(valid[RW] & rw_sel[b]);
        assign mem_wen_o[b]   = ~(rw_write & rw_sel[b]);
        assign mem_wmask_o[b] = rw_write ? ~wb_sel_i : '1;
    end

    assign mem_addr_o  = wb_adr_i[9:2];
    assign mem_wdata_o = wb_dat_i;

    // Unselected blocks contribute zero
    always_comb begin
        wb_rw_dat_o = '0;
        for (int b = 0; b < NB; b++) begin
            wb_rw_dat_o |= mem_rdata_i[b] & {32{rw_sel[b]}};
        end
    end

    // Read-only window
    assign ro_ena_o    = ~(valid[RO] & ro_sel);
    assign ro_addr_o   = wb_adr_i[9:2];
    assign wb_ro_dat_o = ro_sel ? ro_rdata_i : '0;

    a_ack_onehot: assert property (
        @(posedge wb_clk_i) disable iff (!rst_n_i)
        $onehot0(wb_ack_o)
    ) else $error("both ack bits high");

    // The master may drop cyc on the falling edge inside the ack cycle
    a_ack_needs_cyc: assert property (
        @(posedge wb_clk_i) disable iff (!rst_n_i)
        (|wb_ack_o) |-> $past(wb_cyc_i)
    ) else $error("ack outside of a bus cycle");

    a_one_block: assert property (
        @(posedge wb_clk_i) disable iff (!rst_n_i)
        $onehot0(~mem_ena_o)
    ) else $error("more than one RAM block enabled");

endmodule

// ==== storage/storage_top.sv ====
`include "storage_params.svh"

module storage_top (
    input  logic            wb_clk_i,
    input  logic            rst_n_i,

    input  wb_pkg::wb_adr_t wb_adr_i,
    input  wb_pkg::wb_dat_t wb_dat_i,
    input  wb_pkg::wb_sel_t wb_sel_i,
    input  logic            wb_we_i,
    input  logic            wb_cyc_i,
    input  wb_pkg::wb_stb_t wb_stb_i,
    output wb_pkg::wb_stb_t wb_ack_o,
    output wb_pkg::wb_dat_t wb_rw_dat_o,
    output wb_pkg::wb_dat_t wb_ro_dat_o
);

    localparam int NB = `STORAGE_RAM_BLOCKS;

    logic [NB-1:0]                  mem_ena;
    logic [NB-1:0]                  mem_wen;
    mem_pkg::mem_mask_t [NB-1:0]    mem_wmask;
    mem_pkg::mem_addr_t             mem_addr;
    mem_pkg::mem_word_t             mem_wdata;
    mem_pkg::mem_word_t [NB-1:0]    mem_rdata;
    logic                           ro_ena;
    mem_pkg::mem_addr_t             ro_addr;
    mem_pkg::mem_word_t             ro_rdata;

    storage_bridge_wb u_bridge (
        .wb_clk_i    (wb_clk_i),
        .rst_n_i     (rst_n_i),
        .wb_adr_i    (wb_adr_i),
        .wb_dat_i    (wb_dat_i),
        .wb_sel_i    (wb_sel_i),
        .wb_we_i     (wb_we_i),
        .wb_cyc_i    (wb_cyc_i),
        .wb_stb_i    (wb_stb_i),
        .wb_ack_o    (wb_ack_o),
        .wb_rw_dat_o (wb_rw_dat_o),
        .wb_ro_dat_o (wb_ro_dat_o),
        .mem_ena_o   (mem_ena),
        .mem_wen_o   (mem_wen),
        .mem_wmask_o (mem_wmask),
        .mem_addr_o  (mem_addr),
        .mem_wdata_o (mem_wdata),
        .mem_rdata_i (mem_rdata),
        .ro_ena_o    (ro_ena),
        .ro_addr_o   (ro_addr),
        .ro_rdata_i  (ro_rdata)
    );

    for (genvar i = 0; i < NB; i++) begin : g_ram
        logic               ena1_n;
        mem_pkg::mem_addr_t addr1;
        mem_pkg::mem_word_t rdata1;

        if (i == 0) begin : g_ro
            assign ena1_n   = ro_ena;
            assign addr1    = ro_addr;
            assign ro_rdata = rdata1;
        end else begin : g_tie
            assign ena1_n = 1'b1;
            assign addr1  = '0;
        end

        sram_1rw1r u_ram (
            .wb_clk_i   (wb_clk_i),
            .ena0_n_i   (mem_ena[i]),
            .wen0_n_i   (mem_wen[i]),
            .wmask0_n_i (mem_wmask[i]),
            .addr0_i    (mem_addr),
            .wdata0_i   (mem_wdata),
            .rdata0_o   (mem_rdata[i]),
            .ena1_n_i   (ena1_n),
            .addr1_i    (addr1),
            .rdata1_o   (rdata1)
        );
    end

endmodule

// ==== sim/tb_storage_top.sv ====
`include "storage_params.svh"

module tb_storage_top;

    localparam int NB             = `STORAGE_RAM_BLOCKS;
    localparam int DEPTH          = `STORAGE_RAM_DEPTH;
    localparam logic [23:0] UNMAPPED = 24'h50_0000;
    localparam int ACK_LIMIT      = 8;
    localparam int N_RANDOM       = 400;
    // Fill, directed tests and 400 random accesses at up to 4 cycles each
    localparam int TIMEOUT_CYCLES = 4000;

    localparam int OFFS [4] = '{0, 1, 'h55, 'hFF};
    localparam wb_pkg::wb_sel_t LANES [9] = '{
        4'h1, 4'h2, 4'h4, 4'h8, 4'h3, 4'hC, 4'h5, 4'hA, 4'h0
    };

    logic            wb_clk_i;
    logic            rst_n_i;
    wb_pkg::wb_adr_t wb_adr_i;
    wb_pkg::wb_dat_t wb_dat_i;
    wb_pkg::wb_sel_t wb_sel_i;
    logic            wb_we_i;
    logic            wb_cyc_i;
    wb_pkg::wb_stb_t wb_stb_i;
    wb_pkg::wb_stb_t wb_ack_o;
    wb_pkg::wb_dat_t wb_rw_dat_o;
    wb_pkg::wb_dat_t wb_ro_dat_o;

    // Expected contents of every read/write block
    wb_pkg::wb_dat_t ref_mem [NB][DEPTH];

    logic [31:0] rng = 32'hff16_6fd7;
    int          pass_cnt = 0;
    int          fail_cnt = 0;
    int          fails_at_start = 0;
    int          cycle_cnt = 0;

    storage_top UUT (
        .wb_clk_i    (wb_clk_i),
        .rst_n_i     (rst_n_i),
        .wb_adr_i    (wb_adr_i),
        .wb_dat_i    (wb_dat_i),
        .wb_sel_i    (wb_sel_i),
        .wb_we_i     (wb_we_i),
        .wb_cyc_i    (wb_cyc_i),
        .wb_stb_i    (wb_stb_i),
        .wb_ack_o    (wb_ack_o),
        .wb_rw_dat_o (wb_rw_dat_o),
        .wb_ro_dat_o (wb_ro_dat_o)
    );

    initial begin
        wb_clk_i = 1'b0;
        forever #50 wb_clk_i = ~wb_clk_i;
    end

    always @(posedge wb_clk_i) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d clock cycles", cycle_cnt);
            $display("Test FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [23:0] rw_base(input int b);
        case (b)
            0:       return `STORAGE_RW_BASE_0;
            1:       return `STORAGE_RW_BASE_1;
            2:       return `STORAGE_RW_BASE_2;
            default: return `STORAGE_RW_BASE_3;
        endcase
    endfunction

    function automatic wb_pkg::wb_adr_t word_adr(input logic [23:0] base, input int idx);
        return {8'h00, base | 24'(idx << 2)};
    endfunction

    // Block hit by a strobe 0 access, -1 when no window matches
    function automatic int rw_block(input wb_pkg::wb_adr_t adr);
        for (int b = 0; b < NB; b++) begin
            if ((adr[23:0] & `STORAGE_ADR_MASK) == rw_base(b)) begin
                return b;
            end
        end
        return -1;
    endfunction

    function automatic bit ro_hit(input wb_pkg::wb_adr_t adr);
        return (adr[23:0] & `STORAGE_ADR_MASK) == `STORAGE_RO_BASE;
    endfunction

    // Expected read data from the window rules and all prior writes
    function automatic wb_pkg::wb_dat_t ref_read(input int stb_bit, input wb_pkg::wb_adr_t adr);
        int b;
        b = rw_block(adr);
        if (stb_bit == 0 && b >= 0) begin
            return ref_mem[b][adr[9:2]];
        end
        if (stb_bit == 1 && ro_hit(adr)) begin
            return ref_mem[0][adr[9:2]];
        end
        return '0;
    endfunction

    function automatic wb_pkg::wb_dat_t fill_word(input int b, input int idx);
        return {8'h5A, 8'(b), 8'(idx), 8'(idx) ^ 8'h3C};
    endfunction

    task automatic model_write(input int stb_bit, input wb_pkg::wb_adr_t adr,
                               input wb_pkg::wb_dat_t dat, input wb_pkg::wb_sel_t sel);
        int b;
        b = rw_block(adr);
        if (stb_bit == 0 && b >= 0) begin
            for (int i = 0; i < 4; i++) begin
                if (sel[i]) begin
                    ref_mem[b][adr[9:2]][i*8 +: 8] = dat[i*8 +: 8];
                end
            end
        end
    endtask

    task automatic check_dat(input string sig, input wb_pkg::wb_adr_t adr,
                             input wb_pkg::wb_dat_t got, input wb_pkg::wb_dat_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s (address %h) = %h, expected %h",
                     $time, sig, adr, got, exp);
            fail_cnt++;
        end else begin
            pass_cnt++;
        end
    endtask

    task automatic check_ack(input string sig, input wb_pkg::wb_stb_t got,
                             input wb_pkg::wb_stb_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %b, expected %b", $time, sig, got, exp);
            fail_cnt++;
        end else begin
            pass_cnt++;
        end
    endtask

    // Starts and ends on a falling edge, with one idle cycle after the ack
    task automatic bus_access(input int stb_bit, input wb_pkg::wb_adr_t adr, input logic we,
                              input wb_pkg::wb_dat_t dat, input wb_pkg::wb_sel_t sel,
                              output wb_pkg::wb_dat_t rdata);
        int              waited;
        int              exp_lat;
        bit              ack_seen;
        wb_pkg::wb_stb_t exp_ack;
        exp_lat = (stb_bit == 0 && we) ? 1 : 2;
        exp_ack = '0;
        exp_ack[stb_bit] = 1'b1;
        rdata = '0;
        waited = 0;
        ack_seen = 1'b0;
        wb_adr_i = adr;
        wb_dat_i = dat;
        wb_sel_i = sel;
        wb_we_i  = we;
        wb_cyc_i = 1'b1;
        wb_stb_i = exp_ack;
        while (!ack_seen && waited < ACK_LIMIT) begin
            @(negedge wb_clk_i);
            waited++;
            ack_seen = |wb_ack_o;
        end
        if (!ack_seen) begin
            $display("%0t: no ack for strobe %0d at address %h within %0d cycles",
                     $time, stb_bit, adr, ACK_LIMIT);
            fail_cnt++;
        end else begin
            if (waited != exp_lat) begin
                $display("** Error at %0t: wb_ack_o latency = %0d, expected %0d",
                         $time, waited, exp_lat);
                fail_cnt++;
            end
            check_ack("wb_ack_o", wb_ack_o, exp_ack);
            rdata = (stb_bit == 0) ? wb_rw_dat_o : wb_ro_dat_o;
        end
        wb_cyc_i = 1'b0;
        wb_stb_i = '0;
        wb_we_i  = 1'b0;
        @(negedge wb_clk_i);
        // Ack lasts a single cycle
        check_ack("wb_ack_o", wb_ack_o, '0);
    endtask

    task automatic do_write(input int stb_bit, input wb_pkg::wb_adr_t adr,
                            input wb_pkg::wb_dat_t dat, input wb_pkg::wb_sel_t sel);
        wb_pkg::wb_dat_t unused;
        bus_access(stb_bit, adr, 1'b1, dat, sel, unused);
        model_write(stb_bit, adr, dat, sel);
    endtask

    task automatic do_read(input int stb_bit, input wb_pkg::wb_adr_t adr);
        wb_pkg::wb_dat_t got;
        string           sig;
        sig = (stb_bit == 0) ? "wb_rw_dat_o" : "wb_ro_dat_o";
        bus_access(stb_bit, adr, 1'b0, '0, '0, got);
        check_dat(sig, adr, got, ref_read(stb_bit, adr));
    endtask

    task automatic end_test(input string name);
        if (fail_cnt == fails_at_start) begin
            $display("%-12s passed", name);
        end else begin
            $display("%-12s failed with %0d errors", name, fail_cnt - fails_at_start);
        end
        fails_at_start = fail_cnt;
    endtask

    initial begin
        logic [31:0]     r;
        wb_pkg::wb_dat_t d;
        logic [23:0]     base;
        int              w;

        rst_n_i  = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        wb_sel_i = '0;
        wb_we_i  = 1'b0;
        wb_cyc_i = 1'b0;
        wb_stb_i = '0;

        repeat (2) @(negedge wb_clk_i);
        rst_n_i = 1'b1;
        check_ack("wb_ack_o", wb_ack_o, '0);
        @(negedge wb_clk_i);
        check_ack("wb_ack_o", wb_ack_o, '0);
        end_test("reset");

        // Macros power up unknown, so every word gets a known value first
        for (int b = 0; b < NB; b++) begin
            for (int i = 0; i < DEPTH; i++) begin
                do_write(0, word_adr(rw_base(b), i), fill_word(b, i), 4'hF);
            end
        end
        end_test("fill");

        // Reading every block after each write also shows the others unchanged
        for (int k = 0; k < 4; k++) begin
            for (int b = 0; b < NB; b++) begin
                do_write(0, word_adr(rw_base(b), OFFS[k]), {8'hC3, 8'(b), 8'(k), 8'h96}, 4'hF);
                for (int c = 0; c < NB; c++) begin
                    do_read(0, word_adr(rw_base(c), OFFS[k]));
                end
            end
        end
        end_test("rw_words");

        for (int b = 0; b < NB; b++) begin
            for (int k = 0; k < 9; k++) begin
                do_write(0, word_adr(rw_base(b), 'h10 + k), 32'hDEAD_BEEF ^ {8{LANES[k]}},
                         LANES[k]);
                do_read(0, word_adr(rw_base(b), 'h10 + k));
            end
        end
        end_test("byte_lanes");

        for (int k = 0; k < 4; k++) begin
            do_write(0, word_adr(rw_base(0), OFFS[k]), {8'h0F, 8'(k), 16'h7E81}, 4'hF);
            do_read(1, word_adr(`STORAGE_RO_BASE, OFFS[k]));
        end
        end_test("ro_port");

        do_read(0, {8'h00, UNMAPPED});
        do_write(0, word_adr(UNMAPPED, 'h20), 32'hFFFF_FFFF, 4'hF);
        for (int b = 0; b < NB; b++) begin
            do_read(0, word_adr(rw_base(b), 'h20));
        end
        do_read(1, word_adr(UNMAPPED, 'h20));
        end_test("unmapped");

        do_write(0, word_adr(rw_base(0), 3), 32'h0BAD_F00D, 4'hF);
        do_read(0, word_adr(rw_base(0), 3));
        do_read(1, word_adr(`STORAGE_RO_BASE, 3));
        // Strobe 1 writes are acked like reads and store nothing
        do_write(1, word_adr(`STORAGE_RO_BASE, 3), 32'h1234_5678, 4'hF);
        do_read(0, word_adr(rw_base(0), 3));
        end_test("ack_timing");

        for (int n = 0; n < N_RANDOM; n++) begin
            rng = xorshift32(rng);
            r = rng;
            rng = xorshift32(rng);
            d = rng;
            w = int'(r[2:0]) % (NB + 2);
            if (w < NB) begin
                base = rw_base(w);
            end else if (w == NB) begin
                base = `STORAGE_RO_BASE;
            end else begin
                base = UNMAPPED;
            end
            // Bits 15:10 alias inside a window
            if (r[4]) begin
                do_write(int'(r[3]), {8'h00, base | {8'h00, r[31:18], 2'b00}}, d, r[8:5]);
            end else begin
                do_read(int'(r[3]), {8'h00, base | {8'h00, r[31:18], 2'b00}});
            end
        end
        end_test("random");

        $display("checks: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+common
common/wb_pkg.sv
common/mem_pkg.sv
storage/sram_1rw1r.sv
storage/storage_bridge_wb.sv
storage/storage_top.sv
sim/tb_storage_top.sv

// ==== Bender.yml ====
package:
  name: storage

sources:
  - include_dirs:
      - common
    files:
      - common/wb_pkg.sv
      - common/mem_pkg.sv
      - storage/sram_1rw1r.sv
      - storage/storage_bridge_wb.sv
      - storage/storage_top.sv

  - target: test
    include_dirs:
      - common
    files:
      - sim/tb_storage_top.sv
